// File: mem_bridge.f
rtl/mem_bridge_pkg.sv
rtl/mem_req_if.sv
rtl/req_arbiter.sv
rtl/axi_rd_channel.sv
rtl/axi_wr_channel.sv
rtl/mem_bridge_top.sv
verif/tb_clock_gen.sv
verif/axi_slave_model.sv
verif/tb_mem_bridge.sv

// File: verif/tb_mem_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_bridge
    import mem_bridge_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 60;

    logic Clk, aresetn;
    logic inst_req_i, data_req_i, data_wr_i;
    logic [ADDR_W-1:0] inst_addr_i, data_addr_i;
    logic [SIZE_W-1:0] data_size_i;
    logic [DATA_W-1:0] data_wdata_i;
    wire inst_addr_ok_o, inst_data_ok_o, data_addr_ok_o, data_data_ok_o;
    wire [DATA_W-1:0] inst_rdata_o, data_rdata_o, rdata_i, wdata_o;
    wire [ID_W-1:0] arid_o, awid_o, wid_o, rid_i;
    wire [ADDR_W-1:0] araddr_o, awaddr_o;
    wire [AXI_LEN_W-1:0] arlen_o, awlen_o;
    wire [AXI_SIZE_W-1:0] arsize_o, awsize_o;
    wire [AXI_BURST_W-1:0] arburst_o, awburst_o;
    wire [AXI_LOCK_W-1:0] arlock_o, awlock_o;
    wire [AXI_CACHE_W-1:0] arcache_o, awcache_o;
    wire [AXI_PROT_W-1:0] arprot_o, awprot_o;
    wire [STRB_W-1:0] wstrb_o;
    wire arvalid_o, arready_i, rvalid_i, rready_o, awvalid_o, awready_i;
    wire wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;

    logic [DATA_W-1:0] ref_mem [256];
    logic [DATA_W-1:0] exp_inst_rdata, exp_data_rdata, exp_wdata;
    logic [STRB_W-1:0] exp_strb;
    logic [SIZE_W-1:0] exp_wsize;
    logic [ADDR_W-1:0] exp_waddr;
    logic              data_rd_chk, expect_data_win, expect_wr_overlap;

    tb_clock_gen u_clk (.Clk(Clk), .aresetn(aresetn));

    mem_bridge_top UUT (.*, .rresp_i(2'b00), .rlast_i(1'b1), .bid_i(ID_DATA), .bresp_i(2'b00));

    axi_slave_model u_slave (
        .Clk(Clk), .aresetn(aresetn),
        .arid_i(arid_o), .araddr_i(araddr_o), .arvalid_i(arvalid_o), .arready_o(arready_i),
        .rid_o(rid_i), .rdata_o(rdata_i), .rvalid_o(rvalid_i), .rready_i(rready_o),
        .awaddr_i(awaddr_o), .awvalid_i(awvalid_o), .awready_o(awready_i),
        .wdata_i(wdata_o), .wstrb_i(wstrb_o), .wvalid_i(wvalid_o), .wready_o(wready_i),
        .bvalid_o(bvalid_i), .bready_i(bready_o)
    );

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic give_up(input string what);
        $display("timed out waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    assert property (@(posedge Clk) !aresetn |=> !arvalid_o && !awvalid_o && !wvalid_o &&
        !inst_addr_ok_o && !data_addr_ok_o && !inst_data_ok_o && !data_data_ok_o)
        else report_mismatch("outputs active during or right after reset");
    assert property (@(posedge Clk) disable iff (!aresetn)
        inst_addr_ok_o |=> arvalid_o && arid_o == ID_INST && arsize_o == SIZE_WORD)
        else report_mismatch("instruction read issued with wrong id or size");
    assert property (@(posedge Clk) disable iff (!aresetn)
        arvalid_o |-> arlen_o == 4'd0 && arburst_o == 2'b01 && arlock_o == 2'b00 &&
        arcache_o == 4'd0 && arprot_o == 3'd0)
        else report_mismatch("AR length, burst, lock, cache or prot field");
    assert property (@(posedge Clk) disable iff (!aresetn)
        inst_data_ok_o |-> inst_rdata_o == exp_inst_rdata)
        else report_mismatch("instruction read data");
    assert property (@(posedge Clk) disable iff (!aresetn)
        data_data_ok_o && data_rd_chk |-> data_rdata_o == exp_data_rdata)
        else report_mismatch("data read data");
    assert property (@(posedge Clk) disable iff (!aresetn)
        awvalid_o |-> awaddr_o == exp_waddr && awid_o == ID_DATA && awsize_o == exp_wsize)
        else report_mismatch("write address, id or size");
    assert property (@(posedge Clk) disable iff (!aresetn)
        awvalid_o |-> awlen_o == 4'd0 && awburst_o == 2'b01 && awlock_o == 2'b00 &&
        awcache_o == 4'd0 && awprot_o == 3'd0)
        else report_mismatch("AW length, burst, lock, cache or prot field");
    assert property (@(posedge Clk) disable iff (!aresetn)
        wvalid_o |-> wstrb_o == exp_strb && wdata_o == exp_wdata &&
        wid_o == ID_DATA && wlast_o)
        else report_mismatch("write strobe, data, id or last");
    assert property (@(posedge Clk) disable iff (!aresetn)
        expect_data_win |-> data_addr_ok_o && !inst_addr_ok_o)
        else report_mismatch("data read did not win over instruction read");
    assert property (@(posedge Clk) disable iff (!aresetn)
        expect_wr_overlap |-> data_addr_ok_o)
        else report_mismatch("data write not accepted during instruction read");
    assert property (@(posedge Clk) disable iff (!aresetn) arvalid_o && !arready_i |=>
        arvalid_o && $stable(araddr_o) && $stable(arid_o) && $stable(arsize_o))
        else report_mismatch("AR channel changed under back-pressure");
    assert property (@(posedge Clk) disable iff (!aresetn) awvalid_o && !awready_i |=>
        awvalid_o && $stable(awaddr_o) && $stable(awid_o) && $stable(awsize_o))
        else report_mismatch("AW channel changed under back-pressure");
    assert property (@(posedge Clk) disable iff (!aresetn) wvalid_o && !wready_i |=>
        wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
        else report_mismatch("W channel changed under back-pressure");

    // a lane is written when it lies inside the size-aligned span of the access
    function automatic logic [STRB_W-1:0] lanes_for(input logic [SIZE_W-1:0] size,
                                                    input logic [1:0] off);
        int                count;
        int                first;
        logic [STRB_W-1:0] lanes;
        count = 1 << size;
        first = off - (off % count);
        for (int i = 0; i < STRB_W; i++) begin
            lanes[i] = (i >= first) && (i < first + count);
        end
        return lanes;
    endfunction

    task automatic drive_inst(input logic [ADDR_W-1:0] addr);
        @(posedge Clk);
        exp_inst_rdata = ref_mem[addr[9:2]];
        inst_req_i  <= 1'b1;
        inst_addr_i <= addr;
    endtask

    task automatic drive_data(input logic wr, input logic [SIZE_W-1:0] size,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [STRB_W-1:0] lanes;
        lanes = lanes_for(size, addr[1:0]);
        @(posedge Clk);
        if (wr) begin
            exp_strb  = lanes;
            exp_wdata = wdata;
            exp_wsize = size;
            exp_waddr = addr;
            for (int i = 0; i < STRB_W; i++) begin
                if (lanes[i]) ref_mem[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
            end
        end else begin
            exp_data_rdata = ref_mem[addr[9:2]];
            data_rd_chk    = 1'b1;
        end
        data_req_i   <= 1'b1;
        data_wr_i    <= wr;
        data_size_i  <= size;
        data_addr_i  <= addr;
        data_wdata_i <= wdata;
    endtask

    task automatic await_inst_accept();
        int n;
        for (n = 0; n < TIMEOUT_CYCLES && !inst_addr_ok_o; n++) @(posedge Clk);
        if (!inst_addr_ok_o) give_up("instruction addr_ok");
        inst_req_i <= 1'b0;
    endtask

    task automatic await_data_accept();
        int n;
        for (n = 0; n < TIMEOUT_CYCLES && !data_addr_ok_o; n++) @(posedge Clk);
        if (!data_addr_ok_o) give_up("data addr_ok");
        expect_data_win   = 1'b0;
        expect_wr_overlap = 1'b0;
        data_req_i <= 1'b0;
    endtask

    task automatic await_inst_done();
        int n;
        @(posedge Clk);
        for (n = 0; n < TIMEOUT_CYCLES && !inst_data_ok_o; n++) @(posedge Clk);
        if (!inst_data_ok_o) give_up("instruction data_ok");
    endtask

    task automatic await_data_done();
        int n;
        @(posedge Clk);
        for (n = 0; n < TIMEOUT_CYCLES && !data_data_ok_o; n++) @(posedge Clk);
        if (!data_data_ok_o) give_up("data data_ok");
        data_rd_chk = 1'b0;
    endtask

    task automatic data_access(input logic wr, input logic [SIZE_W-1:0] size,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        drive_data(wr, size, addr, wdata);
        await_data_accept();
        await_data_done();
    endtask

    initial begin
        int n;
        inst_req_i = 1'b0;
        inst_addr_i = '0;
        data_req_i = 1'b0;
        data_wr_i = 1'b0;
        data_size_i = SIZE_WORD;
        data_addr_i = '0;
        data_wdata_i = '0;
        data_rd_chk = 1'b0;
        expect_data_win = 1'b0;
        expect_wr_overlap = 1'b0;
        exp_strb = '0;
        exp_wdata = '0;
        exp_wsize = SIZE_WORD;
        exp_waddr = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
        for (n = 0; n < TIMEOUT_CYCLES && !aresetn; n++) @(posedge Clk);
        if (!aresetn) give_up("reset release");

        drive_inst(32'h0000_0040);
        await_inst_accept();
        await_inst_done();

        // every size at every legal offset, each followed by a read-back
        for (int off = 0; off < 4; off++) begin
            data_access(1'b1, SIZE_BYTE, 32'h80 + off, {4{8'h11}} * (off + 1));
            data_access(1'b0, SIZE_WORD, 32'h80, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            data_access(1'b1, SIZE_HALF, 32'h84 + off, 32'h0001_0001 * (16'hbe00 + off));
            data_access(1'b0, SIZE_WORD, 32'h84, '0);
        end
        data_access(1'b1, SIZE_WORD, 32'h88, 32'hcafe_f00d);
        data_access(1'b0, SIZE_WORD, 32'h88, '0);

        fork
            begin
                drive_data(1'b0, SIZE_WORD, 32'h80, '0);
                expect_data_win = 1'b1;
                await_data_accept();
                await_data_done();
            end
            begin
                drive_inst(32'h0000_0044);
                await_inst_accept();
                await_inst_done();
            end
        join

        drive_inst(32'h0000_0100);
        await_inst_accept();
        fork
            await_inst_done();
            begin
                drive_data(1'b1, SIZE_HALF, 32'h8e, 32'h7e57_7e57);
                expect_wr_overlap = 1'b1;
                await_data_accept();
                await_data_done();
            end
        join
        data_access(1'b0, SIZE_WORD, 32'h8c, '0);

        repeat (2) @(posedge Clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/axi_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_slave_model
    import mem_bridge_pkg::*;
(
    input  wire               Clk,
    input  wire               aresetn,
    input  wire  [ID_W-1:0]   arid_i,
    input  wire  [ADDR_W-1:0] araddr_i,
    input  wire               arvalid_i,
    output logic              arready_o,
    output logic [ID_W-1:0]   rid_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              rvalid_o,
    input  wire               rready_i,
    input  wire  [ADDR_W-1:0] awaddr_i,
    input  wire               awvalid_i,
    output logic              awready_o,
    input  wire  [DATA_W-1:0] wdata_i,
    input  wire  [STRB_W-1:0] wstrb_i,
    input  wire               wvalid_i,
    output logic              wready_o,
    output logic              bvalid_o,
    input  wire               bready_i
);

    logic [DATA_W-1:0] mem [256];
    logic [31:0]       lfsr = 32'h3a99db84;
    logic [1:0]        ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic              r_pend, aw_got, w_got, b_pend;
    logic [ID_W-1:0]   ar_id;
    logic [7:0]        ar_idx, aw_idx;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;

    // two bits per delay, one LFSR step for each bit
    function logic [1:0] draw_delay();
        int k;
        for (k = 0; k < 2; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            draw_delay[k] = lfsr[0];
        end
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h33};
        end
    end

    always @(posedge Clk) begin
        if (!aresetn) begin
            {arready_o, rvalid_o, awready_o, wready_o, bvalid_o} <= '0;
            {r_pend, aw_got, w_got, b_pend} <= '0;
            {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} <= '0;
        end else begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            if (arvalid_i && arready_o) begin
                ar_id  <= arid_i;
                ar_idx <= araddr_i[9:2];
                r_pend <= 1'b1;
                r_cnt  <= draw_delay();
                ar_cnt <= draw_delay();
            end else if (arvalid_i && !arready_o && !r_pend && !rvalid_o) begin
                if (ar_cnt == 0) arready_o <= 1'b1;
                else ar_cnt <= ar_cnt - 1;
            end
            if (r_pend) begin
                if (r_cnt == 0) begin
                    rvalid_o <= 1'b1;
                    rid_o    <= ar_id;
                    rdata_o  <= mem[ar_idx];
                    r_pend   <= 1'b0;
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end
            if (rvalid_o && rready_i) rvalid_o <= 1'b0;
            if (awvalid_i && awready_o) begin
                aw_idx <= awaddr_i[9:2];
                aw_got <= 1'b1;
                aw_cnt <= draw_delay();
            end else if (awvalid_i && !awready_o && !aw_got) begin
                if (aw_cnt == 0) awready_o <= 1'b1;
                else aw_cnt <= aw_cnt - 1;
            end
            if (wvalid_i && wready_o) begin
                w_data <= wdata_i;
                w_strb <= wstrb_i;
                w_got  <= 1'b1;
                w_cnt  <= draw_delay();
            end else if (wvalid_i && !wready_o && !w_got) begin
                if (w_cnt == 0) wready_o <= 1'b1;
                else w_cnt <= w_cnt - 1;
            end
            if (aw_got && w_got && !b_pend && !bvalid_o) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (w_strb[i]) mem[aw_idx][8*i +: 8] <= w_data[8*i +: 8];
                end
                b_pend <= 1'b1;
                b_cnt  <= draw_delay();
            end
            if (b_pend) begin
                if (b_cnt == 0) begin
                    bvalid_o <= 1'b1;
                    b_pend   <= 1'b0;
                    aw_got   <= 1'b0;
                    w_got    <= 1'b0;
                end else begin
                    b_cnt <= b_cnt - 1;
                end
            end
            if (bvalid_o && bready_i) bvalid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic Clk,
    output logic aresetn
);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk; // 100 ns period
    end

    initial begin
        aresetn = 1'b0;
        repeat (4) @(posedge Clk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/mem_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bridge_top
    import mem_bridge_pkg::*;
(
    input  wire                    Clk,
    input  wire                    aresetn,

    input  wire                    inst_req_i,
    input  wire  [ADDR_W-1:0]      inst_addr_i,
    output logic                   inst_addr_ok_o,
    output logic                   inst_data_ok_o,
    output logic [DATA_W-1:0]      inst_rdata_o,

    input  wire                    data_req_i,
    input  wire                    data_wr_i,
    input  wire  [SIZE_W-1:0]      data_size_i,
    input  wire  [ADDR_W-1:0]      data_addr_i,
    input  wire  [DATA_W-1:0]      data_wdata_i,
    output logic                   data_addr_ok_o,
    output logic                   data_data_ok_o,
    output logic [DATA_W-1:0]      data_rdata_o,

    output logic [ID_W-1:0]        arid_o,
    output logic [ADDR_W-1:0]      araddr_o,
    output logic [AXI_LEN_W-1:0]   arlen_o,
    output logic [AXI_SIZE_W-1:0]  arsize_o,
    output logic [AXI_BURST_W-1:0] arburst_o,
    output logic [AXI_LOCK_W-1:0]  arlock_o,
    output logic [AXI_CACHE_W-1:0] arcache_o,
    output logic [AXI_PROT_W-1:0]  arprot_o,
    output logic                   arvalid_o,
    input  wire                    arready_i,

    input  wire  [ID_W-1:0]        rid_i,
    input  wire  [DATA_W-1:0]      rdata_i,
    input  wire  [AXI_RESP_W-1:0]  rresp_i,
    input  wire                    rlast_i,
    input  wire                    rvalid_i,
    output logic                   rready_o,

    output logic [ID_W-1:0]        awid_o,
    output logic [ADDR_W-1:0]      awaddr_o,
    output logic [AXI_LEN_W-1:0]   awlen_o,
    output logic [AXI_SIZE_W-1:0]  awsize_o,
    output logic [AXI_BURST_W-1:0] awburst_o,
    output logic [AXI_LOCK_W-1:0]  awlock_o,
    output logic [AXI_CACHE_W-1:0] awcache_o,
    output logic [AXI_PROT_W-1:0]  awprot_o,
    output logic                   awvalid_o,
    input  wire                    awready_i,

    output logic [ID_W-1:0]        wid_o,
    output logic [DATA_W-1:0]      wdata_o,
    output logic [STRB_W-1:0]      wstrb_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  wire                    wready_i,

    input  wire  [ID_W-1:0]        bid_i,
    input  wire  [AXI_RESP_W-1:0]  bresp_i,
    input  wire                    bvalid_i,
    output logic                   bready_o
);

    logic              rd_done;
    logic [ID_W-1:0]   rd_id;
    logic [DATA_W-1:0] rd_data;
    logic              wr_done;
    logic [SIZE_W-1:0] ar_size;
    logic [SIZE_W-1:0] aw_size;

    mem_req_if rd_req ();
    mem_req_if wr_req ();

    req_arbiter u_arbiter (
        .Clk            (Clk),
        .aresetn        (aresetn),
        .inst_req_i     (inst_req_i),
        .inst_addr_i    (inst_addr_i),
        .inst_addr_ok_o (inst_addr_ok_o),
        .inst_data_ok_o (inst_data_ok_o),
        .inst_rdata_o   (inst_rdata_o),
        .data_req_i     (data_req_i),
        .data_wr_i      (data_wr_i),
        .data_size_i    (data_size_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_addr_ok_o (data_addr_ok_o),
        .data_data_ok_o (data_data_ok_o),
        .data_rdata_o   (data_rdata_o),
        .rd_req         (rd_req.arbiter),
        .wr_req         (wr_req.arbiter),
        .rd_done_i      (rd_done),
        .rd_id_i        (rd_id),
        .rd_data_i      (rd_data),
        .wr_done_i      (wr_done)
    );

    axi_rd_channel u_rd_channel (
        .Clk       (Clk),
        .aresetn   (aresetn),
        .req       (rd_req.chan),
        .arid_o    (arid_o),
        .araddr_o  (araddr_o),
        .arsize_o  (ar_size),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rid_i     (rid_i),
        .rdata_i   (rdata_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .rd_done_o (rd_done),
        .rd_id_o   (rd_id),
        .rd_data_o (rd_data)
    );

    axi_wr_channel u_wr_channel (
        .Clk       (Clk),
        .aresetn   (aresetn),
        .req       (wr_req.chan),
        .awid_o    (awid_o),
        .awaddr_o  (awaddr_o),
        .awsize_o  (aw_size),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o),
        .wr_done_o (wr_done)
    );

    // every transfer is a single beat, so the burst fields never change
    assign arsize_o  = {{(AXI_SIZE_W-SIZE_W){1'b0}}, ar_size};
    assign arlen_o   = AXI_LEN_SINGLE;
    assign arburst_o = AXI_BURST_INCR;
    assign arlock_o  = AXI_LOCK_NONE;
    assign arcache_o = AXI_CACHE_NONE;
    assign arprot_o  = AXI_PROT_NONE;

    assign awsize_o  = {{(AXI_SIZE_W-SIZE_W){1'b0}}, aw_size};
    assign awlen_o   = AXI_LEN_SINGLE;
    assign awburst_o = AXI_BURST_INCR;
    assign awlock_o  = AXI_LOCK_NONE;
    assign awcache_o = AXI_CACHE_NONE;
    assign awprot_o  = AXI_PROT_NONE;

    assign wid_o   = awid_o; // AXI3 write data carries the address id
    assign wlast_o = 1'b1;

endmodule

`default_nettype wire

// File: rtl/axi_wr_channel.sv
`timescale 1ns/100ps
`default_nettype none

module axi_wr_channel
    import mem_bridge_pkg::*;
(
    input  wire               Clk,
    input  wire               aresetn,

    mem_req_if.chan           req,

    output logic [ID_W-1:0]   awid_o,
    output logic [ADDR_W-1:0] awaddr_o,
    output logic [SIZE_W-1:0] awsize_o,
    output logic              awvalid_o,
    input  wire               awready_i,

    output logic [DATA_W-1:0] wdata_o,
    output logic [STRB_W-1:0] wstrb_o,
    output logic              wvalid_o,
    input  wire               wready_i,

    input  wire               bvalid_i,
    output logic              bready_o,

    output logic              wr_done_o
);

    logic [STRB_W-1:0] strb_next;
    logic              aw_clear;
    logic              w_clear;

    // byte lanes follow the low address bits
    always_comb begin
        case (req.size)
            SIZE_BYTE: strb_next = 4'b0001 << req.addr[1:0];
            SIZE_HALF: strb_next = req.addr[1] ? 4'b1100 : 4'b0011;
            default:   strb_next = 4'b1111;
        endcase
    end

    // true once that channel has nothing left to hand over
    assign aw_clear = !awvalid_o || awready_i;
    assign w_clear  = !wvalid_o || wready_i;

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            bready_o  <= 1'b0;
            wr_done_o <= 1'b0;
        end else begin
            wr_done_o <= 1'b0;
            if (req.valid) begin
                awvalid_o <= 1'b1;
                wvalid_o  <= 1'b1;
            end else begin
                if (awvalid_o && awready_i) begin
                    awvalid_o <= 1'b0;
                end
                if (wvalid_o && wready_i) begin
                    wvalid_o <= 1'b0;
                end
                if ((awvalid_o || wvalid_o) && aw_clear && w_clear) begin
                    bready_o <= 1'b1; // AW and W may finish in either order
                end
                if (bready_o && bvalid_i) begin
                    bready_o  <= 1'b0;
                    wr_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (req.valid) begin
            awid_o   <= req.id;
            awaddr_o <= req.addr;
            awsize_o <= req.size;
            wdata_o  <= req.wdata; // bytes arrive already replicated across lanes
            wstrb_o  <= strb_next;
        end
    end

    assign req.busy = awvalid_o || wvalid_o || bready_o;

endmodule

`default_nettype wire

// File: rtl/axi_rd_channel.sv
`timescale 1ns/100ps
`default_nettype none

module axi_rd_channel
    import mem_bridge_pkg::*;
(
    input  wire               Clk,
    input  wire               aresetn,

    mem_req_if.chan           req,

    output logic [ID_W-1:0]   arid_o,
    output logic [ADDR_W-1:0] araddr_o,
    output logic [SIZE_W-1:0] arsize_o,
    output logic              arvalid_o,
    input  wire               arready_i,

    input  wire  [ID_W-1:0]   rid_i,
    input  wire  [DATA_W-1:0] rdata_i,
    input  wire               rvalid_i,
    output logic              rready_o,

    output logic              rd_done_o,
    output logic [ID_W-1:0]   rd_id_o,
    output logic [DATA_W-1:0] rd_data_o
);

    // idle when neither flag is set, address phase on arvalid, data phase on rready
    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            rd_done_o <= 1'b0;
        end else begin
            rd_done_o <= 1'b0;
            if (req.valid) begin
                arvalid_o <= 1'b1;
            end else if (arvalid_o && arready_i) begin
                arvalid_o <= 1'b0;
                rready_o  <= 1'b1;
            end else if (rready_o && rvalid_i) begin
                rready_o  <= 1'b0;
                rd_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (req.valid) begin
            arid_o   <= req.id;
            araddr_o <= req.addr;
            arsize_o <= req.size;
        end
        if (rready_o && rvalid_i) begin
            rd_id_o   <= rid_i;
            rd_data_o <= rdata_i;
        end
    end

    assign req.busy = arvalid_o || rready_o;

endmodule

`default_nettype wire

// File: rtl/req_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module req_arbiter
    import mem_bridge_pkg::*;
(
    input  wire               Clk,
    input  wire               aresetn,

    input  wire               inst_req_i,
    input  wire  [ADDR_W-1:0] inst_addr_i,
    output logic              inst_addr_ok_o,
    output logic              inst_data_ok_o,
    output logic [DATA_W-1:0] inst_rdata_o,

    input  wire               data_req_i,
    input  wire               data_wr_i,
    input  wire  [SIZE_W-1:0] data_size_i,
    input  wire  [ADDR_W-1:0] data_addr_i,
    input  wire  [DATA_W-1:0] data_wdata_i,
    output logic              data_addr_ok_o,
    output logic              data_data_ok_o,
    output logic [DATA_W-1:0] data_rdata_o,

    mem_req_if.arbiter        rd_req,
    mem_req_if.arbiter        wr_req,

    input  wire               rd_done_i,
    input  wire  [ID_W-1:0]   rd_id_i,
    input  wire  [DATA_W-1:0] rd_data_i,
    input  wire               wr_done_i
);

    logic inst_pending;
    logic data_pending;
    logic inst_done;
    logic data_done;
    logic inst_free;
    logic data_free;
    logic data_rd_accept;
    logic data_wr_accept;
    logic inst_accept;

    assign inst_done = rd_done_i && (rd_id_i == ID_INST);
    assign data_done = (rd_done_i && (rd_id_i == ID_DATA)) || wr_done_i;

    // a finishing access frees its port in the same cycle
    assign inst_free = !inst_pending || inst_done;
    assign data_free = !data_pending || data_done;

    assign data_rd_accept = data_req_i && !data_wr_i && data_free && !rd_req.busy;
    assign data_wr_accept = data_req_i && data_wr_i && data_free && !wr_req.busy;
    assign inst_accept    = inst_req_i && inst_free && !rd_req.busy && !data_rd_accept; // loads win

    assign inst_addr_ok_o = inst_accept;
    assign data_addr_ok_o = data_rd_accept || data_wr_accept;

    assign rd_req.valid = inst_accept || data_rd_accept;
    assign rd_req.id    = data_rd_accept ? ID_DATA : ID_INST;
    assign rd_req.size  = data_rd_accept ? data_size_i : SIZE_WORD;
    assign rd_req.addr  = data_rd_accept ? data_addr_i : inst_addr_i;
    assign rd_req.wdata = data_wdata_i;

    assign wr_req.valid = data_wr_accept;
    assign wr_req.id    = ID_DATA;
    assign wr_req.size  = data_size_i;
    assign wr_req.addr  = data_addr_i;
    assign wr_req.wdata = data_wdata_i;

    // the read id tells which port the returning word belongs to
    assign inst_data_ok_o = inst_done;
    assign inst_rdata_o   = rd_data_i;
    assign data_data_ok_o = data_done;
    assign data_rdata_o   = rd_data_i;

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            inst_pending <= 1'b0;
            data_pending <= 1'b0;
        end else begin
            if (inst_accept) begin
                inst_pending <= 1'b1;
            end else if (inst_done) begin
                inst_pending <= 1'b0;
            end
            if (data_rd_accept || data_wr_accept) begin
                data_pending <= 1'b1;
            end else if (data_done) begin
                data_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// one accepted CPU access on its way from the arbiter to an AXI engine
interface mem_req_if
    import mem_bridge_pkg::*;
();

    logic              valid; // single cycle, only while busy is low
    logic [ID_W-1:0]   id;
    logic [SIZE_W-1:0] size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              busy;  // engine owns a transaction

    modport arbiter (
        output valid,
        output id,
        output size,
        output addr,
        output wdata,
        input  busy
    );

    modport chan (
        input  valid,
        input  id,
        input  size,
        input  addr,
        input  wdata,
        output busy
    );

endinterface

`default_nettype wire

// File: rtl/mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int SIZE_W = 2;

    localparam int AXI_LEN_W   = 4; // AXI3 length field
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_LOCK_W  = 2;
    localparam int AXI_CACHE_W = 4;
    localparam int AXI_PROT_W  = 3;
    localparam int AXI_RESP_W  = 2;

    // byte count codes shared by the CPU port and the AXI size field
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

    localparam logic [ID_W-1:0] ID_INST = 4'd0; // instruction fetches
    localparam logic [ID_W-1:0] ID_DATA = 4'd1; // loads and stores

    localparam logic [AXI_LEN_W-1:0]   AXI_LEN_SINGLE = 4'd0; // one beat per transfer
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_NONE = 4'b0000;
    localparam logic [AXI_PROT_W-1:0]  AXI_PROT_NONE  = 3'b000;
    localparam logic [AXI_LOCK_W-1:0]  AXI_LOCK_NONE  = 2'b00;

endpackage

`default_nettype wire
